//--- src/dcache_settings.svh
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// ----------------------------------------
// Address and data geometry
// ----------------------------------------

// Word address from the processor.
`define DC_ADDR_W 24
`define DC_DATA_W 16

// Address split: tag, line index, word offset.
`define DC_TAG_W 16
`define DC_IDX_W 6
`define DC_OFF_W 2

// ----------------------------------------
// Store geometry
// ----------------------------------------
`define DC_LINES 64
`define DC_LINE_WORDS 4

`endif

//--- src/dcache_pkg.sv
`include "dcache_settings.svh"

package dcache_pkg;

    // One processor request, held until acknowledged.
    typedef struct packed {
        logic                  we;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic [1:0]            sel;
        logic                  cache_en;
    } dc_req_t;

    // Word 0 sits in the low bits.
    typedef logic [`DC_LINE_WORDS-1:0][`DC_DATA_W-1:0] dc_line_t;

    typedef struct packed {
        logic [`DC_TAG_W-1:0] tag;
        logic                 valid;
        logic                 dirty;
    } dc_tag_entry_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        MERGE,
        UNCACHED
    } dc_state_t;

    typedef enum logic [1:0] {
        OP_LINE_RD,
        OP_LINE_WR,
        OP_SINGLE
    } wb_kind_t;

    typedef struct packed {
        wb_kind_t              kind;
        logic                  we;
        logic [`DC_ADDR_W-1:0] base_addr;
        logic [1:0]            sel;
        logic [`DC_DATA_W-1:0] wdata;
        dc_line_t              line;
    } wb_op_t;

endpackage

//--- src/dcache_mem.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_mem import dcache_pkg::*; #(
    parameter type T     = dc_line_t,
    parameter int  DEPTH = `DC_LINES
) (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  logic [$clog2(DEPTH)-1:0] i_addr,
    input  logic                     i_we,
    input  T                         i_data,
    output T                         o_data
);

    T mem [DEPTH];

    // Read returns the old entry when written in the same cycle.
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int row = 0; row < DEPTH; row++) begin
                mem[row] <= '0;
            end
        end else begin
            if (i_we) begin
                mem[i_addr] <= i_data;
            end
            o_data <= mem[i_addr];
        end
    end

endmodule

//--- src/wb_line_master.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module wb_line_master import dcache_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_op_valid,
    input  wb_op_t                i_op,
    output logic                  o_op_done,
    output dc_line_t              o_line,
    output logic [`DC_DATA_W-1:0] o_rdata,

    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [`DC_ADDR_W-1:0] o_wb_adr,
    output logic [`DC_DATA_W-1:0] o_wb_dat,
    output logic [1:0]            o_wb_sel,
    input  logic [`DC_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_ack
);

    logic [`DC_OFF_W-1:0] beat;
    logic                 is_line;
    logic                 beat_ack;
    logic                 last_beat;
    dc_line_t             collect;

    assign is_line   = (i_op.kind != OP_SINGLE);
    assign beat_ack  = o_wb_cyc && o_wb_stb && i_wb_ack;
    assign last_beat = !is_line || (&beat);
    assign o_op_done = beat_ack && last_beat;

    // ----------------------------------------
    // Bus cycle and beat counter
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_wb_cyc <= 1'b0;
            o_wb_stb <= 1'b0;
            beat     <= '0;
        end else if (!o_wb_cyc) begin
            if (i_op_valid) begin
                o_wb_cyc <= 1'b1;
                o_wb_stb <= 1'b1;
                beat     <= '0;
            end
        end else if (beat_ack) begin
            if (last_beat) begin
                o_wb_cyc <= 1'b0;
                o_wb_stb <= 1'b0;
                beat     <= '0;
            end else begin
                beat <= beat + 1'b1;
            end
        end
    end

    // The operation is held by the controller, so these follow it directly.
    assign o_wb_we  = o_wb_cyc && i_op.we;
    assign o_wb_adr = is_line ? {i_op.base_addr[`DC_ADDR_W-1:`DC_OFF_W], beat}
                              : i_op.base_addr;
    assign o_wb_dat = is_line ? i_op.line[beat] : i_op.wdata;
    assign o_wb_sel = is_line ? 2'b11 : i_op.sel;

    // ----------------------------------------
    // Fetched line assembly
    // ----------------------------------------
    always_ff @(posedge i_clk) begin
        if (beat_ack && !o_wb_we) begin
            collect[beat] <= i_wb_dat;
        end
    end

    // Last word bypasses the register so the line is whole at done.
    always_comb begin
        o_line       = collect;
        o_line[beat] = i_wb_dat;
    end

    assign o_rdata = i_wb_dat;

endmodule

//--- src/dcache_ctrl.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_req,
    input  dc_req_t               i_cpu_req,
    output logic                  o_ack,
    output logic [`DC_DATA_W-1:0] o_rdata,

    output logic [`DC_IDX_W-1:0]  o_idx,
    output logic                  o_tag_we,
    output dc_tag_entry_t         o_tag_wr,
    input  dc_tag_entry_t         i_tag_rd,
    output logic                  o_line_we,
    output dc_line_t              o_line_wr,
    input  dc_line_t              i_line_rd,

    output logic                  o_op_valid,
    output wb_op_t                o_op,
    input  logic                  i_op_done,
    input  dc_line_t              i_op_line,
    input  logic [`DC_DATA_W-1:0] i_op_rdata
);

    dc_state_t             state;
    dc_state_t             state_nxt;
    dc_line_t              work_line;
    dc_line_t              merged_line;
    logic [`DC_TAG_W-1:0]  victim_tag;
    logic [`DC_TAG_W-1:0]  req_tag;
    logic [`DC_OFF_W-1:0]  req_off;
    logic                  hit;
    logic                  victim_dirty;

    function automatic logic [`DC_DATA_W-1:0] merge_word(
        input logic [`DC_DATA_W-1:0] old_word,
        input logic [`DC_DATA_W-1:0] new_word,
        input logic [1:0]            sel
    );
        logic [`DC_DATA_W-1:0] res;
        res = old_word;
        if (sel[0]) begin
            res[7:0] = new_word[7:0];
        end
        if (sel[1]) begin
            res[15:8] = new_word[15:8];
        end
        return res;
    endfunction

    assign req_tag = i_cpu_req.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign o_idx   = i_cpu_req.addr[`DC_OFF_W +: `DC_IDX_W];
    assign req_off = i_cpu_req.addr[`DC_OFF_W-1:0];

    // Store outputs are valid in LOOKUP for the index read in IDLE.
    assign hit          = i_tag_rd.valid && (i_tag_rd.tag == req_tag);
    assign victim_dirty = i_tag_rd.valid && i_tag_rd.dirty;

    always_comb begin
        merged_line          = work_line;
        merged_line[req_off] = merge_word(work_line[req_off], i_cpu_req.wdata,
                                          i_cpu_req.sel);
    end

    // ----------------------------------------
    // State machine
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (i_req) begin
                    state_nxt = i_cpu_req.cache_en ? LOOKUP : UNCACHED;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    state_nxt = i_cpu_req.we ? MERGE : IDLE;
                end else begin
                    state_nxt = victim_dirty ? WRITEBACK : FILL;
                end
            end
            WRITEBACK: if (i_op_done) state_nxt = FILL;
            FILL: begin
                if (i_op_done) begin
                    state_nxt = i_cpu_req.we ? MERGE : IDLE;
                end
            end
            MERGE: state_nxt = IDLE;
            UNCACHED: if (i_op_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Hit line or victim, then the fetched line on a fill.
    always_ff @(posedge i_clk) begin
        if (state == LOOKUP) begin
            work_line  <= i_line_rd;
            victim_tag <= i_tag_rd.tag;
        end else if (state == FILL && i_op_done) begin
            work_line <= i_op_line;
        end
    end

    // ----------------------------------------
    // Stores, memory operation, CPU reply
    // ----------------------------------------
    always_comb begin
        o_tag_we  = 1'b0;
        o_line_we = 1'b0;
        o_tag_wr  = '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
        o_line_wr = i_op_line;
        if (state == FILL && i_op_done) begin
            o_tag_we  = 1'b1;
            o_line_we = 1'b1;
        end else if (state == MERGE) begin
            o_tag_we       = 1'b1;
            o_line_we      = 1'b1;
            o_tag_wr.dirty = 1'b1;
            o_line_wr      = merged_line;
        end
    end

    always_comb begin
        o_op.kind      = OP_SINGLE;
        o_op.we        = i_cpu_req.we;
        o_op.base_addr = i_cpu_req.addr;
        o_op.sel       = i_cpu_req.sel;
        o_op.wdata     = i_cpu_req.wdata;
        o_op.line      = work_line;
        if (state == WRITEBACK) begin
            o_op.kind      = OP_LINE_WR;
            o_op.we        = 1'b1;
            o_op.base_addr = {victim_tag, o_idx, {`DC_OFF_W{1'b0}}};
        end else if (state == FILL) begin
            o_op.kind      = OP_LINE_RD;
            o_op.we        = 1'b0;
            o_op.base_addr = {req_tag, o_idx, {`DC_OFF_W{1'b0}}};
        end
    end

    assign o_op_valid = (state == WRITEBACK) || (state == FILL) || (state == UNCACHED);

    assign o_ack = (state == LOOKUP && hit && !i_cpu_req.we)
                || (state == FILL && i_op_done && !i_cpu_req.we)
                || (state == MERGE)
                || (state == UNCACHED && i_op_done);

    always_comb begin
        case (state)
            FILL:     o_rdata = i_op_line[req_off];
            UNCACHED: o_rdata = i_op_rdata;
            default:  o_rdata = i_line_rd[req_off];
        endcase
    end

endmodule

//--- src/dcache_top.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module dcache_top import dcache_pkg::*; (
    input  logic                  i_clk,
    input  logic                  i_rst,

    input  logic                  i_req,
    input  dc_req_t               i_cpu_req,
    output logic                  o_ack,
    output logic [`DC_DATA_W-1:0] o_rdata,

    output logic                  o_wb_cyc,
    output logic                  o_wb_stb,
    output logic                  o_wb_we,
    output logic [`DC_ADDR_W-1:0] o_wb_adr,
    output logic [`DC_DATA_W-1:0] o_wb_dat,
    output logic [1:0]            o_wb_sel,
    input  logic [`DC_DATA_W-1:0] i_wb_dat,
    input  logic                  i_wb_ack
);

    logic [`DC_IDX_W-1:0]  idx;
    logic                  tag_we;
    dc_tag_entry_t         tag_wr;
    dc_tag_entry_t         tag_rd;
    logic                  line_we;
    dc_line_t              line_wr;
    dc_line_t              line_rd;
    logic                  op_valid;
    wb_op_t                op;
    logic                  op_done;
    dc_line_t              op_line;
    logic [`DC_DATA_W-1:0] op_rdata;

    dcache_ctrl u_ctrl (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (i_req),
        .i_cpu_req  (i_cpu_req),
        .o_ack      (o_ack),
        .o_rdata    (o_rdata),
        .o_idx      (idx),
        .o_tag_we   (tag_we),
        .o_tag_wr   (tag_wr),
        .i_tag_rd   (tag_rd),
        .o_line_we  (line_we),
        .o_line_wr  (line_wr),
        .i_line_rd  (line_rd),
        .o_op_valid (op_valid),
        .o_op       (op),
        .i_op_done  (op_done),
        .i_op_line  (op_line),
        .i_op_rdata (op_rdata)
    );

    // Tag and data stores share one index.
    dcache_mem #(.T(dc_tag_entry_t), .DEPTH(`DC_LINES)) u_tags (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_addr (idx),
        .i_we   (tag_we),
        .i_data (tag_wr),
        .o_data (tag_rd)
    );

    dcache_mem #(.T(dc_line_t), .DEPTH(`DC_LINES)) u_lines (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_addr (idx),
        .i_we   (line_we),
        .i_data (line_wr),
        .o_data (line_rd)
    );

    wb_line_master u_master (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_op_valid (op_valid),
        .i_op       (op),
        .o_op_done  (op_done),
        .o_line     (op_line),
        .o_rdata    (op_rdata),
        .o_wb_cyc   (o_wb_cyc),
        .o_wb_stb   (o_wb_stb),
        .o_wb_we    (o_wb_we),
        .o_wb_adr   (o_wb_adr),
        .o_wb_dat   (o_wb_dat),
        .o_wb_sel   (o_wb_sel),
        .i_wb_dat   (i_wb_dat),
        .i_wb_ack   (i_wb_ack)
    );

endmodule

//--- bench/wb_mem_model.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module wb_mem_model #(
    parameter int          DEPTH = 1024,
    parameter logic [31:0] SEED  = 32'd75566
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_cyc,
    input  logic                  i_stb,
    input  logic                  i_we,
    input  logic [`DC_ADDR_W-1:0] i_adr,
    input  logic [`DC_DATA_W-1:0] i_dat,
    input  logic [1:0]            i_sel,
    output logic [`DC_DATA_W-1:0] o_dat,
    output logic                  o_ack,
    output logic                  o_range_err
);

    localparam int AW = $clog2(DEPTH);

    logic [`DC_DATA_W-1:0] mem [DEPTH];
    logic [31:0]           lfsr;
    logic [1:0]            wait_cnt;
    logic                  busy;

    // Galois form, x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    initial begin
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = 16'(a * 7 + 3);
        end
    end

    // ----------------------------------------
    // Slave beat with random wait states
    // ----------------------------------------
    always @(posedge i_clk) begin
        logic [31:0] s1;
        logic [31:0] s2;
        if (i_rst) begin
            lfsr        <= SEED;
            wait_cnt    <= '0;
            busy        <= 1'b0;
            o_ack       <= 1'b0;
            o_range_err <= 1'b0;
        end else begin
            o_ack <= 1'b0;
            if (i_cyc && i_stb && !o_ack) begin
                if (!busy) begin
                    // Two delay bits, one step each.
                    s1       = lfsr_step(lfsr);
                    s2       = lfsr_step(s1);
                    wait_cnt <= {lfsr[0], s1[0]};
                    lfsr     <= s2;
                    busy     <= 1'b1;
                end else if (wait_cnt != 2'd0) begin
                    wait_cnt <= wait_cnt - 1'b1;
                end else begin
                    busy  <= 1'b0;
                    o_ack <= 1'b1;
                    if (i_adr >= DEPTH) begin
                        o_range_err <= 1'b1;
                    end else if (i_we) begin
                        if (i_sel[0]) begin
                            mem[i_adr[AW-1:0]][7:0] <= i_dat[7:0];
                        end
                        if (i_sel[1]) begin
                            mem[i_adr[AW-1:0]][15:8] <= i_dat[15:8];
                        end
                    end else begin
                        o_dat <= mem[i_adr[AW-1:0]];
                    end
                end
            end
        end
    end

endmodule

//--- bench/tb_dcache.sv
`timescale 1ns/1ps
`include "dcache_settings.svh"

module tb_dcache import dcache_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RST_CYCLES = 16;
    localparam int ROW_CYCLES = 200;
    localparam int MEM_WORDS  = 1024;

    typedef struct packed {
        logic                  we;
        logic [`DC_ADDR_W-1:0] addr;
        logic [`DC_DATA_W-1:0] wdata;
        logic [1:0]            sel;
        logic                  cache_en;
        logic [`DC_DATA_W-1:0] exp_rdata;
        logic [2:0]            rd_beats;
        logic [2:0]            wr_beats;
        logic [`DC_ADDR_W-1:0] rd_base;
        logic [`DC_ADDR_W-1:0] wr_base;
        logic                  hit;
        logic                  chk_mem;
        logic [`DC_ADDR_W-1:0] chk_base;
        dc_line_t              chk_line;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  req;
    dc_req_t               cpu_req;
    logic                  ack;
    logic [`DC_DATA_W-1:0] rdata;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic [`DC_ADDR_W-1:0] wb_adr;
    logic [`DC_DATA_W-1:0] wb_dat_w;
    logic [`DC_DATA_W-1:0] wb_dat_r;
    logic [1:0]            wb_sel;
    logic                  wb_ack;
    logic                  range_err;

    row_t                  rows[$];
    row_t                  cur;
    logic [`DC_DATA_W-1:0] ref_mem [MEM_WORDS];
    int                    errors;
    int                    failed_tests;
    int                    rd_cnt;
    int                    wr_cnt;
    logic                  cyc_seen;
    logic                  started;
    logic                  built;

    dcache_top dut0 (
        .i_clk     (clk),
        .i_rst     (rst),
        .i_req     (req),
        .i_cpu_req (cpu_req),
        .o_ack     (ack),
        .o_rdata   (rdata),
        .o_wb_cyc  (wb_cyc),
        .o_wb_stb  (wb_stb),
        .o_wb_we   (wb_we),
        .o_wb_adr  (wb_adr),
        .o_wb_dat  (wb_dat_w),
        .o_wb_sel  (wb_sel),
        .i_wb_dat  (wb_dat_r),
        .i_wb_ack  (wb_ack)
    );

    wb_mem_model #(.DEPTH(MEM_WORDS)) mem0 (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_cyc       (wb_cyc),
        .i_stb       (wb_stb),
        .i_we        (wb_we),
        .i_adr       (wb_adr),
        .i_dat       (wb_dat_w),
        .i_sel       (wb_sel),
        .o_dat       (wb_dat_r),
        .o_ack       (wb_ack),
        .o_range_err (range_err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [`DC_ADDR_W-1:0] line_base(input logic [`DC_ADDR_W-1:0] a);
        return {a[`DC_ADDR_W-1:`DC_OFF_W], {`DC_OFF_W{1'b0}}};
    endfunction

    function automatic logic [15:0] sel_merge(input logic [15:0] old_w,
                                              input logic [15:0] new_w,
                                              input logic [1:0]  sel);
        logic [15:0] mask;
        mask = {{8{sel[1]}}, {8{sel[0]}}};
        return (old_w & ~mask) | (new_w & mask);
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
        errors++;
    endtask

    // Expected read data and victim lines follow the reference memory in table order.
    task automatic add_row(input logic we, input logic [`DC_ADDR_W-1:0] addr,
                           input logic [15:0] wdata, input logic [1:0] sel,
                           input logic cache_en, input int rd_beats, input int wr_beats,
                           input logic [`DC_ADDR_W-1:0] wr_base);
        row_t r;
        r           = '0;
        r.we        = we;
        r.addr      = addr;
        r.wdata     = wdata;
        r.sel       = sel;
        r.cache_en  = cache_en;
        r.exp_rdata = ref_mem[addr[9:0]];
        if (we) begin
            ref_mem[addr[9:0]] = sel_merge(ref_mem[addr[9:0]], wdata, sel);
        end
        r.rd_beats = 3'(rd_beats);
        r.wr_beats = 3'(wr_beats);
        r.rd_base  = cache_en ? line_base(addr) : addr;
        r.wr_base  = wr_base;
        r.hit      = cache_en && rd_beats == 0 && wr_beats == 0;
        r.chk_mem  = (wr_beats != 0);
        r.chk_base = line_base(wr_base);
        for (int k = 0; k < `DC_LINE_WORDS; k++) begin
            r.chk_line[k] = ref_mem[r.chk_base[9:0] + k];
        end
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row(1'b0, 24'h000024, 16'h0000, 2'b11, 1'b1, 4, 0, 24'h0);
        add_row(1'b0, 24'h000026, 16'h0000, 2'b11, 1'b1, 0, 0, 24'h0);
        add_row(1'b0, 24'h000150, 16'h0000, 2'b11, 1'b1, 4, 0, 24'h0);
        add_row(1'b1, 24'h000025, 16'ha5c3, 2'b01, 1'b1, 0, 0, 24'h0);
        add_row(1'b1, 24'h000026, 16'h5a7e, 2'b10, 1'b1, 0, 0, 24'h0);
        add_row(1'b1, 24'h000027, 16'h1234, 2'b11, 1'b1, 0, 0, 24'h0);
        add_row(1'b0, 24'h000025, 16'h0000, 2'b11, 1'b1, 0, 0, 24'h0);
        add_row(1'b0, 24'h000026, 16'h0000, 2'b11, 1'b1, 0, 0, 24'h0);
        add_row(1'b0, 24'h000027, 16'h0000, 2'b11, 1'b1, 0, 0, 24'h0);
        // Same index and a new tag evict dirty line 0x24 first.
        add_row(1'b0, 24'h000124, 16'h0000, 2'b11, 1'b1, 4, 4, 24'h000024);
        add_row(1'b0, 24'h000025, 16'h0000, 2'b11, 1'b1, 4, 0, 24'h0);
        add_row(1'b1, 24'h000052, 16'hc0de, 2'b11, 1'b1, 4, 0, 24'h0);
        add_row(1'b0, 24'h000052, 16'h0000, 2'b11, 1'b1, 0, 0, 24'h0);
        add_row(1'b0, 24'h000252, 16'h0000, 2'b11, 1'b1, 4, 4, 24'h000050);
        // Uncached.
        add_row(1'b1, 24'h000301, 16'hbeef, 2'b10, 1'b0, 0, 1, 24'h000301);
        add_row(1'b0, 24'h000301, 16'h0000, 2'b11, 1'b0, 1, 0, 24'h0);
        add_row(1'b0, 24'h000302, 16'h0000, 2'b01, 1'b0, 1, 0, 24'h0);
        add_row(1'b1, 24'h000303, 16'h77aa, 2'b01, 1'b0, 0, 1, 24'h000303);
        add_row(1'b0, 24'h000303, 16'h0000, 2'b11, 1'b0, 1, 0, 24'h0);
    endtask

    // ----------------------------------------
    // Bus monitor
    // ----------------------------------------
    always @(negedge clk) begin
        if (!rst && !started) begin
            if (ack !== 1'b0) report_mismatch("o_ack before first request", ack, 0);
            if (wb_cyc !== 1'b0) report_mismatch("o_wb_cyc before first request", wb_cyc, 0);
        end
        // Strobe stands for the whole burst and never outside it.
        if (!rst && !wb_cyc && wb_stb !== 1'b0) begin
            report_mismatch("o_wb_stb outside a bus cycle", wb_stb, 0);
        end else if (!rst && wb_cyc && wb_stb !== 1'b1) begin
            report_mismatch("o_wb_stb inside a bus cycle", wb_stb, 1);
        end
        if (started && wb_cyc) begin
            cyc_seen = 1'b1;
        end
        if (wb_cyc && wb_stb && wb_ack) begin
            if (wb_sel !== (cur.cache_en ? 2'b11 : cur.sel)) begin
                report_mismatch("o_wb_sel", wb_sel, cur.cache_en ? 2'b11 : cur.sel);
            end
            if (wb_we) begin
                if (wb_adr !== cur.wr_base + wr_cnt) begin
                    report_mismatch("o_wb_adr (write)", wb_adr, cur.wr_base + wr_cnt);
                end
                if (cur.cache_en && wb_dat_w !== cur.chk_line[wr_cnt % 4]) begin
                    report_mismatch("o_wb_dat", wb_dat_w, cur.chk_line[wr_cnt % 4]);
                end else if (!cur.cache_en && wb_dat_w !== cur.wdata) begin
                    report_mismatch("o_wb_dat", wb_dat_w, cur.wdata);
                end
                wr_cnt++;
            end else begin
                if (wb_adr !== cur.rd_base + rd_cnt) begin
                    report_mismatch("o_wb_adr (read)", wb_adr, cur.rd_base + rd_cnt);
                end
                rd_cnt++;
            end
        end
    end

    // ----------------------------------------
    // Request driver and checks
    // ----------------------------------------
    task automatic run_row(input int n);
        int                    lat;
        int                    errs_before;
        int                    exp_lat;
        logic                  got_ack;
        logic [`DC_DATA_W-1:0] got;
        logic [`DC_DATA_W-1:0] model_word;
        errs_before = errors;
        lat         = 0;
        got_ack     = 1'b0;
        got         = '0;
        @(posedge clk);
        #1;
        cur              = rows[n];
        rd_cnt           = 0;
        wr_cnt           = 0;
        cyc_seen         = 1'b0;
        started          = 1'b1;
        cpu_req.we       = cur.we;
        cpu_req.addr     = cur.addr;
        cpu_req.wdata    = cur.wdata;
        cpu_req.sel      = cur.sel;
        cpu_req.cache_en = cur.cache_en;
        req              = 1'b1;
        while (!got_ack) begin
            @(negedge clk);
            lat++;
            if (ack) begin
                got_ack = 1'b1;
                got     = rdata;
            end
        end
        @(posedge clk);
        #1;
        req = 1'b0;

        if (!cur.we && got !== cur.exp_rdata) report_mismatch("o_rdata", got, cur.exp_rdata);
        if (rd_cnt != cur.rd_beats) report_mismatch("read beats", rd_cnt, cur.rd_beats);
        if (wr_cnt != cur.wr_beats) report_mismatch("write beats", wr_cnt, cur.wr_beats);
        if (cur.hit && cyc_seen) report_mismatch("o_wb_cyc during hit", cyc_seen, 0);
        exp_lat = cur.we ? 3 : 2;
        if (cur.hit && lat != exp_lat) report_mismatch("o_ack latency", lat, exp_lat);
        if (cur.chk_mem) begin
            for (int k = 0; k < `DC_LINE_WORDS; k++) begin
                model_word = mem0.mem[cur.chk_base[9:0] + k];
                if (model_word !== cur.chk_line[k]) begin
                    report_mismatch($sformatf("memory word %0h", cur.chk_base + k),
                                    model_word, cur.chk_line[k]);
                end
            end
        end
        if (errors != errs_before) begin
            failed_tests++;
        end
        $display("test %0d: %s %s addr %h, %0d cycles, %s", n, cur.we ? "write" : "read",
                 cur.cache_en ? "cached" : "uncached", cur.addr, lat,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int limit;
        wait (built);
        limit = (rows.size() * ROW_CYCLES + RST_CYCLES) * CLK_PERIOD;
        #(limit);
        $display("Watchdog expired: run did not finish within %0d ns", limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        req          = 1'b0;
        cpu_req      = '0;
        cur          = '0;
        errors       = 0;
        failed_tests = 0;
        rd_cnt       = 0;
        wr_cnt       = 0;
        cyc_seen     = 1'b0;
        started      = 1'b0;
        built        = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            ref_mem[a] = 16'(a * 7 + 3);
        end
        build_table();
        built = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        // Quiet stretch after reset.
        repeat (5) @(posedge clk);
        for (int n = 0; n < rows.size(); n++) begin
            run_row(n);
        end
        if (range_err) begin
            $display("Memory model saw an address outside its array");
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d check errors",
                 rows.size(), failed_tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

//--- project.f
+incdir+src
src/dcache_pkg.sv
src/dcache_mem.sv
src/wb_line_master.sv
src/dcache_ctrl.sv
src/dcache_top.sv
bench/wb_mem_model.sv
bench/tb_dcache.sv

//--- Bender.yml
package:
  name: dcache

sources:
  - include_dirs:
      - src
    files:
      - src/dcache_pkg.sv
      - src/dcache_mem.sv
      - src/wb_line_master.sv
      - src/dcache_ctrl.sv
      - src/dcache_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - bench/wb_mem_model.sv
      - bench/tb_dcache.sv
